// ==== Makefile ====
TOP       ?= tb_adc_trigger
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: TOP FILELIST BUILD LOG VERILATOR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test ended without a result"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== filelist.f ====
src/trg_cfg_pkg.sv
src/trg_types_pkg.sv
src/hit_if.sv
src/hit_detect.sv
src/acq_window.sv
src/hit_capture.sv
src/adc_trigger.sv
tests/adc_trigger_asserts.sv
tests/tb_adc_trigger.sv

// ==== src/acq_window.sv ====
`timescale 1ns/100ps
`default_nettype none

module acq_window
  import trg_cfg_pkg::*;
(
  input  logic    AXIS_ACLK,
  input  logic    hit_flag_negedge,
  input  logic    s_axis_tvalid,
  hit_if.consumer hit_bus,
  output logic    triggered
);

  localparam logic [post_cnt_width-1:0] post_done = post_cnt_width'(post_len);
  localparam logic [post_cnt_width-1:0] post_sat  = post_cnt_width'(post_len + 1);
  localparam logic [acq_cnt_width-1:0]  acq_done  = acq_cnt_width'(acq_len);
  localparam logic [acq_cnt_width-1:0]  acq_sat   = acq_cnt_width'(acq_len + 1);

  logic [post_cnt_width-1:0] post_cnt;
  logic [acq_cnt_width-1:0]  acq_cnt;
  logic                      finalize;
  logic                      over_len;

  // cycles since the hit ended, parked at post_sat when idle
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      post_cnt <= post_sat;
    end else if (hit_bus.fall) begin
      post_cnt <= '0;
    end else if (post_cnt < post_sat) begin
      post_cnt <= post_cnt + 1'b1;
    end
  end

  // cycles since the hit started
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      acq_cnt <= acq_sat;
    end else if (hit_bus.rise) begin
      acq_cnt <= '0;
    end else if (acq_cnt < acq_sat) begin
      acq_cnt <= acq_cnt + 1'b1;
    end
  end

  // keeps the trigger up for the post-hit tail
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      finalize <= 1'b0;
    end else if (hit_bus.fall) begin
      finalize <= 1'b1;
    end else if (post_cnt == post_done) begin
      finalize <= 1'b0;
    end
  end

  // window has hit its maximum length, held until the next rise
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      over_len <= 1'b0;
    end else if (hit_bus.rise) begin
      over_len <= 1'b0;
    end else if (acq_cnt == acq_done) begin
      over_len <= 1'b1;
    end
  end

  // registered so it lines up with the delayed data
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      triggered <= 1'b0;
    end else begin
      triggered <= s_axis_tvalid & ~over_len & (hit_bus.hit_next | finalize);
    end
  end

endmodule

`default_nettype wire

// ==== src/adc_trigger.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_trigger
  import trg_types_pkg::*;
(
  input  logic        AXIS_ACLK,
  input  logic        hit_flag_negedge,
  input  beat_t       s_axis_tdata,
  input  logic        s_axis_tvalid,
  input  adc_sample_t threshold,
  input  adc_sample_t baseline,
  input  time_stamp_t current_time,
  output beat_t       data,
  output logic        valid,
  output logic        triggered,
  output time_stamp_t time_stamp,
  output adc_sample_t baseline_when_hit,
  output adc_sample_t threshold_when_hit
);

  hit_if hit_bus ();

  hit_detect hit_detect_i (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s_axis_tdata     (s_axis_tdata),
    .threshold        (threshold),
    .baseline         (baseline),
    .hit_bus          (hit_bus.detector)
  );

  acq_window acq_window_i (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s_axis_tvalid    (s_axis_tvalid),
    .hit_bus          (hit_bus.consumer),
    .triggered        (triggered)
  );

  hit_capture hit_capture_i (
    .AXIS_ACLK          (AXIS_ACLK),
    .hit_flag_negedge   (hit_flag_negedge),
    .current_time       (current_time),
    .threshold          (threshold),
    .baseline           (baseline),
    .hit_bus            (hit_bus.consumer),
    .time_stamp         (time_stamp),
    .baseline_when_hit  (baseline_when_hit),
    .threshold_when_hit (threshold_when_hit)
  );

  // one stage of delay to match the trigger latency
  always_ff @(posedge AXIS_ACLK) begin
    data <= s_axis_tdata;
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      valid <= 1'b0;
    end else begin
      valid <= s_axis_tvalid;
    end
  end

endmodule

`default_nettype wire

// ==== src/hit_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module hit_capture
  import trg_types_pkg::*;
(
  input  logic        AXIS_ACLK,
  input  logic        hit_flag_negedge,
  input  time_stamp_t current_time,
  input  adc_sample_t threshold,
  input  adc_sample_t baseline,
  hit_if.consumer     hit_bus,
  output time_stamp_t time_stamp,
  output adc_sample_t baseline_when_hit,
  output adc_sample_t threshold_when_hit
);

  // snapshot of the context at the start of each hit
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      time_stamp         <= '0;
      baseline_when_hit  <= '0;
      threshold_when_hit <= '0;
    end else if (hit_bus.rise) begin
      time_stamp         <= current_time;
      baseline_when_hit  <= baseline;
      threshold_when_hit <= threshold;
    end
  end

endmodule

`default_nettype wire

// ==== src/hit_detect.sv ====
`timescale 1ns/100ps
`default_nettype none

module hit_detect
  import trg_cfg_pkg::*;
  import trg_types_pkg::*;
(
  input  logic        AXIS_ACLK,
  input  logic        hit_flag_negedge,
  input  beat_t       s_axis_tdata,
  input  adc_sample_t threshold,
  input  adc_sample_t baseline,
  hit_if.detector     hit_bus
);

  adc_sample_t              sample [lanes];
  // one extra bit so the subtraction cannot wrap
  logic signed [adc_width:0] diff  [lanes];
  logic [lanes-1:0]         lane_hit;
  logic                     hit_q;

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    // sample sits in the top bits of its lane
    assign sample[i]   = s_axis_tdata[lane_width*i + lane_width - 1 -: adc_width];
    assign diff[i]     = sample[i] - baseline;
    assign lane_hit[i] = (diff[i] >= threshold);
  end

  // any lane over threshold counts as a hit
  assign hit_bus.hit_next = |lane_hit;

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= hit_bus.hit_next;
    end
  end

  assign hit_bus.hit = hit_q;

  // edges seen against the registered level
  assign hit_bus.rise = hit_bus.hit_next & ~hit_q;
  assign hit_bus.fall = ~hit_bus.hit_next & hit_q;

endmodule

`default_nettype wire

// ==== src/hit_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface hit_if;

  // registered hit level
  logic hit;
  // this cycle's hit level, before the register
  logic hit_next;
  // single-cycle edge pulses
  logic rise;
  logic fall;

  modport detector (
    output hit,
    output hit_next,
    output rise,
    output fall
  );

  modport consumer (
    input hit,
    input hit_next,
    input rise,
    input fall
  );

endinterface

`default_nettype wire

// ==== src/trg_cfg_pkg.sv ====
`default_nettype none

package trg_cfg_pkg;

  // sample and beat geometry
  localparam int adc_width   = 12;
  localparam int lane_width  = 16;
  localparam int lanes       = 8;
  localparam int tdata_width = lanes * lane_width;
  localparam int ts_width    = 44;

  // acquisition window, in clock cycles
  localparam int post_len = 38;
  localparam int acq_len  = 100;

  // counters hold one step past their limit when idle
  localparam int post_cnt_width = $clog2(post_len + 2);
  localparam int acq_cnt_width  = $clog2(acq_len + 2);

endpackage

`default_nettype wire

// ==== src/trg_types_pkg.sv ====
`default_nettype none

package trg_types_pkg;

  import trg_cfg_pkg::*;

  // one ADC sample, two's complement
  typedef logic signed [adc_width-1:0] adc_sample_t;

  // one stream beat, lanes packed low to high
  typedef logic [tdata_width-1:0] beat_t;

  // free-running time counter value
  typedef logic [ts_width-1:0] time_stamp_t;

endpackage

`default_nettype wire

// ==== tests/adc_trigger_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_trigger_asserts
  import trg_cfg_pkg::*;
  import trg_types_pkg::*;
(
  input logic        AXIS_ACLK,
  input logic        hit_flag_negedge,
  input beat_t       s_axis_tdata,
  input logic        s_axis_tvalid,
  input adc_sample_t threshold,
  input adc_sample_t baseline,
  input logic        valid,
  input logic        triggered
);

  int               fail_count = 0;
  logic [lanes-1:0] lane_over;
  logic             seen_hit;

  // lanes meeting the threshold, widened to avoid wrap
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign lane_over[i] = int'($signed(s_axis_tdata[lane_width*i + lane_width - 1 -: adc_width]))
                          - int'(baseline) >= int'(threshold);
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      seen_hit <= 1'b0;
    end else if (|lane_over) begin
      seen_hit <= 1'b1;
    end
  end

  valid_follows_tvalid: assert property (@(posedge AXIS_ACLK) disable iff (hit_flag_negedge)
    !$past(hit_flag_negedge) |-> valid == $past(s_axis_tvalid))
    else begin
      fail_count = fail_count + 1;
      $error("valid is not the tvalid of the previous cycle");
    end

  no_trigger_without_valid: assert property (@(posedge AXIS_ACLK) disable iff (hit_flag_negedge)
    !s_axis_tvalid |=> !triggered)
    else begin
      fail_count = fail_count + 1;
      $error("triggered high after a cycle without tvalid");
    end

  // nothing triggers before the first hit
  no_trigger_before_hit: assert property (@(posedge AXIS_ACLK) disable iff (hit_flag_negedge)
    triggered |-> seen_hit)
    else begin
      fail_count = fail_count + 1;
      $error("triggered high before any sample was a hit");
    end

endmodule

bind adc_trigger adc_trigger_asserts adc_trigger_asserts_i (.*);

`default_nettype wire

// ==== tests/tb_adc_trigger.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_adc_trigger
  import trg_cfg_pkg::*;
  import trg_types_pkg::*;
();

  // about three times the combined test length
  localparam int max_cycles = 2000;

  logic        AXIS_ACLK;
  logic        hit_flag_negedge;
  beat_t       s_axis_tdata;
  logic        s_axis_tvalid;
  adc_sample_t threshold;
  adc_sample_t baseline;
  time_stamp_t current_time;
  beat_t       data;
  logic        valid;
  logic        triggered;
  time_stamp_t time_stamp;
  adc_sample_t baseline_when_hit;
  adc_sample_t threshold_when_hit;

  int seed = 34492;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int tests_run = 0;
  int assert_fails = 0;
  bit model_on = 1'b0;

  // reference model state
  logic        m_hit, m_fin, m_over, m_trig, m_valid;
  int          m_post, m_acq;
  beat_t       m_data;
  time_stamp_t m_ts;
  adc_sample_t m_bl, m_th;

  adc_trigger adc_trigger_i (.*);

  initial begin
    AXIS_ACLK = 1'b0;
    forever #5 AXIS_ACLK = ~AXIS_ACLK;
  end

  // hit rule per lane, worked in plain integers
  function automatic bit beat_has_hit(beat_t b, adc_sample_t bl, adc_sample_t th);
    int s;
    for (int i = 0; i < lanes; i++) begin
      s = $signed(b[lane_width*i + lane_width - 1 -: adc_width]);
      if (s - int'(bl) >= int'(th))
        return 1'b1;
    end
    return 1'b0;
  endfunction

  // random lanes starting at low, spread over 256 codes
  function automatic beat_t quiet_beat(int low);
    beat_t b;
    int r;
    for (int i = 0; i < lanes; i++) begin
      r = $random(seed);
      b[lane_width*i +: lane_width] = {adc_sample_t'(low + (r & 255)), r[15:12]};
    end
    return b;
  endfunction

  function automatic beat_t with_lane(beat_t b, int lane, int sample);
    b[lane_width*lane + lane_width - 1 -: adc_width] = adc_sample_t'(sample);
    return b;
  endfunction

  // drive a beat just after an edge, return after the edge that takes it
  task automatic apply_beat(beat_t b, logic v);
    current_time  = current_time + time_stamp_t'(1);
    s_axis_tdata  = b;
    s_axis_tvalid = v;
    @(posedge AXIS_ACLK);
    #1;
  endtask

  task automatic expect_value(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic expect_beat(beat_t got, beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: data is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic close_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  // trigger model built from the window rules
  always @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin : ref_model
    bit hn;
    if (hit_flag_negedge) begin
      m_hit   <= 1'b0;
      m_fin   <= 1'b0;
      m_over  <= 1'b0;
      m_trig  <= 1'b0;
      m_valid <= 1'b0;
      m_post  <= post_len + 1;
      m_acq   <= acq_len + 1;
      m_ts    <= '0;
      m_bl    <= '0;
      m_th    <= '0;
    end else begin
      hn = beat_has_hit(s_axis_tdata, baseline, threshold);
      m_hit   <= hn;
      m_valid <= s_axis_tvalid;
      m_data  <= s_axis_tdata;
      m_trig  <= s_axis_tvalid && !m_over && (hn || m_fin);
      // falling edge of the hit starts the tail
      if (!hn && m_hit) begin
        m_post <= 0;
        m_fin  <= 1'b1;
      end else begin
        if (m_post <= post_len)
          m_post <= m_post + 1;
        if (m_post == post_len)
          m_fin <= 1'b0;
      end
      // rising edge opens a new window and takes a snapshot
      if (hn && !m_hit) begin
        m_acq  <= 0;
        m_over <= 1'b0;
        m_ts   <= current_time;
        m_bl   <= baseline;
        m_th   <= threshold;
      end else begin
        if (m_acq <= acq_len)
          m_acq <= m_acq + 1;
        if (m_acq == acq_len)
          m_over <= 1'b1;
      end
    end
  end

  // outputs are stable at the falling edge
  always @(negedge AXIS_ACLK) begin
    if (model_on) begin
      expect_value("triggered", triggered, m_trig);
      expect_value("valid", valid, m_valid);
      expect_value("time_stamp", time_stamp, m_ts);
      expect_value("baseline_when_hit", baseline_when_hit, m_bl);
      expect_value("threshold_when_hit", threshold_when_hit, m_th);
      if (m_valid)
        expect_beat(data, m_data);
    end
  end

  always @(posedge AXIS_ACLK) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic test_pass_through();
    int e0;
    int r;
    beat_t b;
    e0 = errors;
    baseline  = '0;
    threshold = 12'sd500;
    for (int k = 0; k < 40; k++) begin
      b = quiet_beat(-256);
      r = $random(seed);
      apply_beat(b, r[0]);
      expect_value("valid", valid, r[0]);
      expect_value("triggered below threshold", triggered, 1'b0);
      expect_beat(data, b);
    end
    close_test("pass-through", e0);
  endtask

  task automatic test_short_hit();
    int e0;
    e0 = errors;
    for (int k = 0; k < 5; k++) begin
      // one beat of the hit arrives without tvalid
      apply_beat(with_lane(quiet_beat(-256), 3, 900), k != 2);
      expect_value("triggered during hit", triggered, k != 2);
    end
    for (int k = 0; k < post_len + 5; k++) begin
      apply_beat(quiet_beat(-256), 1'b1);
      if (k >= 1 && k <= post_len)
        expect_value("triggered in tail", triggered, 1'b1);
      if (k >= post_len + 2)
        expect_value("triggered after tail", triggered, 1'b0);
    end
    close_test("short hit", e0);
  endtask

  task automatic test_long_hit();
    int e0;
    e0 = errors;
    for (int k = 0; k < 150; k++) begin
      apply_beat(with_lane(quiet_beat(-256), 6, 1500), 1'b1);
      if (k < acq_len)
        expect_value("triggered inside window", triggered, 1'b1);
      if (k >= acq_len + 2)
        expect_value("triggered past window", triggered, 1'b0);
    end
    // window stays closed through the tail
    for (int k = 0; k < post_len + 5; k++) begin
      apply_beat(quiet_beat(-256), 1'b1);
      expect_value("triggered after long hit", triggered, 1'b0);
    end
    close_test("long hit", e0);
  endtask

  task automatic test_capture();
    int e0;
    time_stamp_t t_hit;
    e0 = errors;
    baseline  = 12'sd100;
    threshold = 12'sd200;
    repeat (3) apply_beat(quiet_beat(-256), 1'b1);
    t_hit = current_time + time_stamp_t'(1);
    for (int k = 0; k < 6; k++) begin
      apply_beat(with_lane(quiet_beat(-256), 1, 1000), 1'b1);
      expect_value("time_stamp", time_stamp, t_hit);
      expect_value("baseline_when_hit", baseline_when_hit, 12'sd100);
      expect_value("threshold_when_hit", threshold_when_hit, 12'sd200);
      // new context without a new rise
      baseline  = 12'sd50;
      threshold = 12'sd300;
    end
    repeat (post_len + 5) apply_beat(quiet_beat(-256), 1'b1);
    close_test("capture", e0);
  endtask

  task automatic test_signed_lanes();
    int e0;
    int edge_val;
    beat_t b;
    e0 = errors;
    baseline  = -12'sd200;
    threshold = 12'sd50;
    edge_val  = int'(baseline) + int'(threshold);
    for (int lane = 0; lane < lanes; lane++) begin
      repeat (post_len + 4) apply_beat(quiet_beat(-700), 1'b1);
      b = with_lane(quiet_beat(-700), lane, edge_val - 1);
      apply_beat(b, 1'b1);
      expect_value("triggered on near miss", triggered, beat_has_hit(b, baseline, threshold));
      b = with_lane(quiet_beat(-700), lane, edge_val);
      apply_beat(b, 1'b1);
      apply_beat(b, 1'b1);
      expect_value("triggered on lane hit", triggered, beat_has_hit(b, baseline, threshold));
    end
    close_test("signed compare", e0);
  endtask

  initial begin
    hit_flag_negedge = 1'b1;
    s_axis_tdata     = '0;
    s_axis_tvalid    = 1'b0;
    threshold        = '0;
    baseline         = '0;
    current_time     = '0;
    repeat (4) @(posedge AXIS_ACLK);
    #1;
    hit_flag_negedge = 1'b0;
    model_on = 1'b1;
    test_pass_through();
    test_short_hit();
    test_long_hit();
    test_capture();
    test_signed_lanes();
    model_on = 1'b0;
    assert_fails = adc_trigger_i.adc_trigger_asserts_i.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
